/* verilog/mem_bus_pkg.sv */
// ******************
// memory bus package
// widths and vector types shared by every memory port
// ******************
`default_nettype none

package mem_bus_pkg;

  // byte address width
  localparam int ADDR_WIDTH = 32;
  // data word width
  localparam int WORD_WIDTH = 32;
  // one enable bit per byte lane
  localparam int BYTE_EN_WIDTH = WORD_WIDTH / 8;

  // full byte address, word aligned in practice
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  // one data word
  typedef logic [WORD_WIDTH-1:0] word_t;
  // bit n selects byte lane n
  typedef logic [BYTE_EN_WIDTH-1:0] byte_en_t;

endpackage

`default_nettype wire

/* verilog/mem_ctrl_pkg.sv */
// ******************
// memory control package
// arbiter FSM state encoding
// ******************
`default_nettype none

package mem_ctrl_pkg;

  // arbiter states
  // idle, data owns the RAM, instruction owns the RAM,
  // instruction access started and held until done
  typedef enum logic [1:0] {
    ARB_IDLE       = 2'd0,
    ARB_DATA_REQ   = 2'd1,
    ARB_INSTR_REQ  = 2'd2,
    ARB_INSTR_WAIT = 2'd3
  } arb_state_t;

endpackage

`default_nettype wire

/* verilog/wait_state_ram.sv */
// ******************
// wait state RAM
// word RAM with byte-masked writes, busy for a set
// number of cycles on every access
// ******************
`timescale 1ns/1ps
`default_nettype none

module wait_state_ram #(
  parameter int ADDR_W      = 8,
  parameter int WAIT_CYCLES = 2
) (
  input  logic                  CLK,
  input  logic                  nRST,

  // request
  input  logic                  i_ren,
  input  logic                  i_wen,
  input  mem_bus_pkg::addr_t    i_addr,
  input  mem_bus_pkg::word_t    i_wdata,
  input  mem_bus_pkg::byte_en_t i_byte_en,

  // response
  output logic                  o_busy,
  output mem_bus_pkg::word_t    o_rdata
);

  localparam int DEPTH = 2 ** ADDR_W;
  localparam int LANES = $bits(mem_bus_pkg::byte_en_t);
  // wide enough to reach WAIT_CYCLES, at least one bit
  localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  mem_bus_pkg::word_t mem [DEPTH];

  logic [CNT_W-1:0]  wait_cnt;
  logic [ADDR_W-1:0] word_idx;
  logic              req;
  logic              done;

  assign req      = i_ren | i_wen;
  // drop the byte offset
  assign word_idx = i_addr[ADDR_W+1:2];
  // completion once the wait count is used up
  assign done     = req && (wait_cnt == CNT_W'(WAIT_CYCLES));
  // idle also reads as busy
  assign o_busy   = ~done;
  // stored word, valid in the completion cycle
  assign o_rdata  = mem[word_idx];

  // wait counter
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (!req || done) begin
      // restart for the next access
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // RAM contents start cleared
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // byte-masked write in the completion cycle
  always @(posedge CLK) begin
    if (done && i_wen) begin
      for (int b = 0; b < LANES; b++) begin
        if (i_byte_en[b]) begin
          mem[word_idx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/memory_arbiter.sv */
// ******************
// memory arbiter
// grants the single-port RAM to the data or instruction
// client, data first, and aligns store data to byte lanes
// ******************
`timescale 1ns/1ps
`default_nettype none

module memory_arbiter (
  input  logic                  CLK,
  input  logic                  nRST,

  // data client request
  input  logic                  i_d_ren,
  input  logic                  i_d_wen,
  input  mem_bus_pkg::addr_t    i_d_addr,
  input  mem_bus_pkg::word_t    i_d_wdata,
  input  mem_bus_pkg::byte_en_t i_d_byte_en,
  // data client response
  output logic                  o_d_busy,
  output mem_bus_pkg::word_t    o_d_rdata,

  // instruction client request, read only
  input  logic                  i_i_ren,
  input  mem_bus_pkg::addr_t    i_i_addr,
  // instruction client response
  output logic                  o_i_busy,
  output mem_bus_pkg::word_t    o_i_rdata,

  // request toward the RAM
  output logic                  o_ram_ren,
  output logic                  o_ram_wen,
  output mem_bus_pkg::addr_t    o_ram_addr,
  output mem_bus_pkg::word_t    o_ram_wdata,
  output mem_bus_pkg::byte_en_t o_ram_byte_en,
  // response from the RAM
  input  logic                  i_ram_busy,
  input  mem_bus_pkg::word_t    i_ram_rdata
);

  mem_ctrl_pkg::arb_state_t state;
  mem_ctrl_pkg::arb_state_t next_state;

  // data client wants the bus
  logic d_req;
  // store data moved onto the enabled lanes
  mem_bus_pkg::word_t aligned_wdata;

  assign d_req = i_d_ren | i_d_wen;

  // state register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= mem_ctrl_pkg::ARB_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // next state
  always_comb begin
    next_state = state;
    case (state)
      mem_ctrl_pkg::ARB_IDLE: begin
        // data wins a tie
        if (d_req) begin
          next_state = mem_ctrl_pkg::ARB_DATA_REQ;
        end else if (i_i_ren) begin
          next_state = mem_ctrl_pkg::ARB_INSTR_REQ;
        end
      end

      mem_ctrl_pkg::ARB_DATA_REQ: begin
        // hold until the RAM completes
        if (!i_ram_busy) begin
          next_state = mem_ctrl_pkg::ARB_IDLE;
        end
      end

      mem_ctrl_pkg::ARB_INSTR_REQ: begin
        // access now started, lock it in
        if (!i_ram_busy) begin
          next_state = mem_ctrl_pkg::ARB_IDLE;
        end else begin
          next_state = mem_ctrl_pkg::ARB_INSTR_WAIT;
        end
      end

      mem_ctrl_pkg::ARB_INSTR_WAIT: begin
        // a pending data request waits for this to finish
        if (!i_ram_busy) begin
          next_state = mem_ctrl_pkg::ARB_IDLE;
        end
      end

      default: begin
        next_state = mem_ctrl_pkg::ARB_IDLE;
      end
    endcase
  end

  // store lane alignment from the byte enable
  always_comb begin
    case (i_d_byte_en)
      4'h1, 4'h3, 4'hF: aligned_wdata = i_d_wdata;
      4'h2:             aligned_wdata = i_d_wdata << 8;
      4'h4, 4'hC:       aligned_wdata = i_d_wdata << 16;
      4'h8:             aligned_wdata = i_d_wdata << 24;
      default:          aligned_wdata = i_d_wdata;
    endcase
  end

  // request routing and busy return
  always_comb begin
    // no owner, nothing forwarded
    o_ram_ren     = 1'b0;
    o_ram_wen     = 1'b0;
    o_ram_addr    = '0;
    o_ram_wdata   = aligned_wdata;
    o_ram_byte_en = '0;
    o_d_busy      = 1'b1;
    o_i_busy      = 1'b1;

    case (state)
      mem_ctrl_pkg::ARB_DATA_REQ: begin
        o_ram_ren     = i_d_ren;
        o_ram_wen     = i_d_wen;
        o_ram_addr    = i_d_addr;
        o_ram_byte_en = i_d_byte_en;
        o_d_busy      = i_ram_busy;
      end

      mem_ctrl_pkg::ARB_INSTR_REQ,
      mem_ctrl_pkg::ARB_INSTR_WAIT: begin
        // fetch is always a full word
        o_ram_ren     = i_i_ren;
        o_ram_addr    = i_i_addr;
        o_ram_byte_en = '1;
        o_i_busy      = i_ram_busy;
      end

      default: begin
      end
    endcase
  end

  // read data goes to both, busy tells who owns it
  assign o_d_rdata = i_ram_rdata;
  assign o_i_rdata = i_ram_rdata;

endmodule

`default_nettype wire

/* verilog/memory_subsystem.sv */
// ******************
// memory subsystem
// data and instruction ports sharing one RAM
// through the arbiter
// ******************
`timescale 1ns/1ps
`default_nettype none

module memory_subsystem #(
  parameter int ADDR_W      = 8,
  parameter int WAIT_CYCLES = 2
) (
  input  logic                  CLK,
  input  logic                  nRST,

  // data port
  input  logic                  i_d_ren,
  input  logic                  i_d_wen,
  input  mem_bus_pkg::addr_t    i_d_addr,
  input  mem_bus_pkg::word_t    i_d_wdata,
  input  mem_bus_pkg::byte_en_t i_d_byte_en,
  output logic                  o_d_busy,
  output mem_bus_pkg::word_t    o_d_rdata,

  // instruction port
  input  logic                  i_i_ren,
  input  mem_bus_pkg::addr_t    i_i_addr,
  output logic                  o_i_busy,
  output mem_bus_pkg::word_t    o_i_rdata
);

  // arbiter to RAM
  logic                  ram_ren;
  logic                  ram_wen;
  mem_bus_pkg::addr_t    ram_addr;
  mem_bus_pkg::word_t    ram_wdata;
  mem_bus_pkg::byte_en_t ram_byte_en;
  logic                  ram_busy;
  mem_bus_pkg::word_t    ram_rdata;

  memory_arbiter u_memory_arbiter (
    .CLK           (CLK),
    .nRST          (nRST),
    .i_d_ren       (i_d_ren),
    .i_d_wen       (i_d_wen),
    .i_d_addr      (i_d_addr),
    .i_d_wdata     (i_d_wdata),
    .i_d_byte_en   (i_d_byte_en),
    .o_d_busy      (o_d_busy),
    .o_d_rdata     (o_d_rdata),
    .i_i_ren       (i_i_ren),
    .i_i_addr      (i_i_addr),
    .o_i_busy      (o_i_busy),
    .o_i_rdata     (o_i_rdata),
    .o_ram_ren     (ram_ren),
    .o_ram_wen     (ram_wen),
    .o_ram_addr    (ram_addr),
    .o_ram_wdata   (ram_wdata),
    .o_ram_byte_en (ram_byte_en),
    .i_ram_busy    (ram_busy),
    .i_ram_rdata   (ram_rdata)
  );

  // depth and wait count set here
  wait_state_ram #(
    .ADDR_W      (ADDR_W),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_wait_state_ram (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_ren     (ram_ren),
    .i_wen     (ram_wen),
    .i_addr    (ram_addr),
    .i_wdata   (ram_wdata),
    .i_byte_en (ram_byte_en),
    .o_busy    (ram_busy),
    .o_rdata   (ram_rdata)
  );

endmodule

`default_nettype wire

/* sim/memory_arbiter_checker.sv */
// ******************
// memory arbiter checker
// ownership and no-preemption assertions
// ******************
`timescale 1ns/1ps
`default_nettype none

module memory_arbiter_checker (
  input  logic                     CLK,
  input  logic                     nRST,
  input  mem_ctrl_pkg::arb_state_t i_state,
  input  logic                     i_d_busy,
  input  logic                     i_i_busy,
  input  logic                     i_ram_ren,
  input  logic                     i_ram_wen
);

  // failures so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // fetch holds the RAM and has not completed yet
  logic fetch_open;

  assign fetch_open = ((i_state == mem_ctrl_pkg::ARB_INSTR_REQ) ||
                       (i_state == mem_ctrl_pkg::ARB_INSTR_WAIT)) && i_i_busy;

  // one owner at a time
  one_owner: assert property (@(posedge CLK) disable iff (!nRST)
    !(!i_d_busy && !i_i_busy))
  else begin
    fail_count = fail_count + 1;
    $error("both clients completed in the same cycle");
  end

  // nothing reaches the RAM from idle
  req_in_grant: assert property (@(posedge CLK) disable iff (!nRST)
    (i_ram_ren || i_ram_wen) |-> (i_state != mem_ctrl_pkg::ARB_IDLE))
  else begin
    fail_count = fail_count + 1;
    $error("RAM request forwarded while the arbiter is idle");
  end

  // an unfinished fetch keeps the data client waiting
  data_after_fetch: assert property (@(posedge CLK) disable iff (!nRST)
    fetch_open |=> i_d_busy)
  else begin
    fail_count = fail_count + 1;
    $error("data completion while an instruction access was unfinished");
  end

endmodule

bind memory_arbiter memory_arbiter_checker u_memory_arbiter_checker (
  .CLK        (CLK),
  .nRST       (nRST),
  .i_state    (state),
  .i_d_busy   (o_d_busy),
  .i_i_busy   (o_i_busy),
  .i_ram_ren  (o_ram_ren),
  .i_ram_wen  (o_ram_wen)
);

`default_nettype wire

/* sim/memory_subsystem_tb.sv */
// ******************
// memory subsystem testbench
// directed and seeded random data and fetch
// traffic against a reference RAM model
// ******************
`timescale 1ns/1ps
`default_nettype none

module memory_subsystem_tb;

  localparam int ADDR_W      = 8;
  localparam int WAIT_CYCLES = 2;
  localparam int CLK_PERIOD  = 8;
  localparam int N_XFERS     = 200;
  // random transfers of both ports plus the directed ones
  localparam int N_TOTAL     = 2 * N_XFERS + 32;
  localparam int WATCHDOG_NS = N_TOTAL * (WAIT_CYCLES + 4) * 2 * CLK_PERIOD;
  localparam mem_bus_pkg::addr_t LANE_ADDR = 32'h40;

  logic                  CLK;
  logic                  nRST;
  logic                  d_ren;
  logic                  d_wen;
  mem_bus_pkg::addr_t    d_addr;
  mem_bus_pkg::word_t    d_wdata;
  mem_bus_pkg::byte_en_t d_byte_en;
  logic                  d_busy;
  mem_bus_pkg::word_t    d_rdata;
  logic                  instr_ren;
  mem_bus_pkg::addr_t    instr_addr;
  logic                  instr_busy;
  mem_bus_pkg::word_t    instr_rdata;

  // reference RAM, absent words read as zero
  mem_bus_pkg::word_t model [mem_bus_pkg::addr_t];
  // full word first, then the sub-word patterns
  mem_bus_pkg::byte_en_t be_list [7] = '{4'hF, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC};

  memory_subsystem #(
    .ADDR_W      (ADDR_W),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_memory_subsystem (
    .CLK         (CLK),
    .nRST        (nRST),
    .i_d_ren     (d_ren),
    .i_d_wen     (d_wen),
    .i_d_addr    (d_addr),
    .i_d_wdata   (d_wdata),
    .i_d_byte_en (d_byte_en),
    .o_d_busy    (d_busy),
    .o_d_rdata   (d_rdata),
    .i_i_ren     (instr_ren),
    .i_i_addr    (instr_addr),
    .o_i_busy    (instr_busy),
    .o_i_rdata   (instr_rdata)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // watchdog, sized from the transfer count
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: transfers still running after %0d ns", WATCHDOG_NS);
    end_with_failure();
  end

  task automatic end_with_failure();
    $display("** FAIL **");
    $fatal(1, "run stopped on the first failure");
  endtask

  task automatic report_mismatch(input string name, input mem_bus_pkg::word_t got,
                                 input mem_bus_pkg::word_t exp);
    $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
    end_with_failure();
  endtask

  // shift that moves store data onto its lanes
  function automatic int store_shift(input mem_bus_pkg::byte_en_t be);
    case (be)
      4'h2:       return 8;
      4'h4, 4'hC: return 16;
      4'h8:       return 24;
      default:    return 0;
    endcase
  endfunction

  function automatic mem_bus_pkg::word_t merge_store(input mem_bus_pkg::word_t old,
      input mem_bus_pkg::word_t wdata, input mem_bus_pkg::byte_en_t be);
    mem_bus_pkg::word_t aligned;
    mem_bus_pkg::word_t result;
    aligned = wdata << store_shift(be);
    result  = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = aligned[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic mem_bus_pkg::word_t model_read(input mem_bus_pkg::addr_t addr);
    if (model.exists(addr)) begin
      return model[addr];
    end
    return '0;
  endfunction

  // one data transfer, returns at the completion cycle
  task automatic data_access(input logic wr, input mem_bus_pkg::addr_t addr,
      input mem_bus_pkg::word_t wdata, input mem_bus_pkg::byte_en_t be, output time done_at);
    mem_bus_pkg::word_t exp;
    @(posedge CLK);
    d_ren     <= ~wr;
    d_wen     <= wr;
    d_addr    <= addr;
    d_wdata   <= wdata;
    d_byte_en <= be;
    do begin
      @(negedge CLK);
    end while (d_busy);
    done_at = $time;
    if (wr) begin
      model[addr] = merge_store(model_read(addr), wdata, be);
    end else begin
      exp = model_read(addr);
      assert (d_rdata == exp) else report_mismatch("o_d_rdata", d_rdata, exp);
    end
  endtask

  task automatic instr_read(input mem_bus_pkg::addr_t addr, output time done_at);
    mem_bus_pkg::word_t exp;
    @(posedge CLK);
    instr_ren  <= 1'b1;
    instr_addr <= addr;
    do begin
      @(negedge CLK);
    end while (instr_busy);
    done_at = $time;
    exp     = model_read(addr);
    assert (instr_rdata == exp) else report_mismatch("o_i_rdata", instr_rdata, exp);
  endtask

  task automatic data_idle(input int cycles);
    repeat (cycles) begin
      @(posedge CLK);
      d_ren <= 1'b0;
      d_wen <= 1'b0;
    end
  endtask

  task automatic instr_idle(input int cycles);
    repeat (cycles) begin
      @(posedge CLK);
      instr_ren <= 1'b0;
    end
  endtask

  // reads, full writes and sub-word stores over 16 words
  task automatic random_data_traffic();
    int  op;
    int  idx;
    time t;
    mem_bus_pkg::addr_t addr;
    for (int n = 0; n < N_XFERS; n++) begin
      op   = $urandom_range(0, 3);
      idx  = $urandom_range(1, 6);
      addr = mem_bus_pkg::addr_t'($urandom_range(0, 15)) << 2;
      data_access(op != 0, addr, $urandom(), (op == 1) ? 4'hF : be_list[idx], t);
      data_idle($urandom_range(0, 2));
    end
    data_idle(1);
  endtask

  task automatic random_instr_traffic();
    time t;
    for (int n = 0; n < N_XFERS; n++) begin
      instr_read(mem_bus_pkg::addr_t'($urandom_range(0, 15)) << 2, t);
      instr_idle($urandom_range(0, 2));
    end
    instr_idle(1);
  endtask

  initial begin : main
    time d_done;
    time i_done;
    void'($urandom(93));
    nRST       = 1'b0;
    d_ren      = 1'b0;
    d_wen      = 1'b0;
    d_addr     = '0;
    d_wdata    = '0;
    d_byte_en  = '0;
    instr_ren  = 1'b0;
    instr_addr = '0;
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;

    // no owner before the first request
    @(negedge CLK);
    assert (d_busy) else report_mismatch("o_d_busy", mem_bus_pkg::word_t'(d_busy), 32'h1);
    assert (instr_busy)
      else report_mismatch("o_i_busy", mem_bus_pkg::word_t'(instr_busy), 32'h1);

    // every lane pattern stored, read back through both ports
    foreach (be_list[k]) begin
      data_access(1'b1, LANE_ADDR, $urandom(), be_list[k], d_done);
      data_access(1'b0, LANE_ADDR, '0, 4'hF, d_done);
      data_idle(1);
      instr_read(LANE_ADDR, i_done);
      instr_idle(1);
    end

    // both ports request from idle in the same cycle
    fork
      begin
        data_access(1'b1, 32'h44, $urandom(), 4'hF, d_done);
        data_idle(1);
      end
      begin
        instr_read(32'h44, i_done);
        instr_idle(1);
      end
    join
    assert (d_done < i_done) else begin
      $display("data transfer did not finish before the fetch issued with it");
      end_with_failure();
    end

    // data request lands while a fetch is in flight
    fork
      begin
        instr_read(32'h48, i_done);
        instr_idle(1);
      end
      begin
        @(posedge CLK);
        @(posedge CLK);
        data_access(1'b1, 32'h48, $urandom(), 4'hF, d_done);
        data_idle(1);
      end
    join
    assert (i_done < d_done) else begin
      $display("fetch in flight was overtaken by a later data request");
      end_with_failure();
    end

    fork
      random_data_traffic();
      random_instr_traffic();
    join

    if (u_memory_subsystem.u_memory_arbiter.u_memory_arbiter_checker.fail_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("arbiter checker reported assertion failures");
      end_with_failure();
    end
  end

endmodule

`default_nettype wire

/* memory_subsystem.f */
verilog/mem_bus_pkg.sv
verilog/mem_ctrl_pkg.sv
verilog/wait_state_ram.sv
verilog/memory_arbiter.sv
verilog/memory_subsystem.sv
sim/memory_arbiter_checker.sv
sim/memory_subsystem_tb.sv

/* Makefile */
# Verilator build and run of the memory subsystem testbench
VERILATOR ?= verilator
TOP       ?= memory_subsystem_tb
FILELIST  ?= memory_subsystem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

# the run exits non-zero on any failure
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
